// ==== files.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/instruction_decode.sv
hdl/datapath.sv
hdl/cpu_core.sv
verification/tb_memory.sv
verification/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cpu_tb -f files.f --Mdir obj_dir -o cpu_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/cpu_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== verification/cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module cpu_tb;
    import cpu_pkg::*;

    // one program step whose preset byte goes to the operand address before the run
    typedef struct packed {
        data_t opcode;
        data_t lo;      // for JMP the number of bytes jumped over
        data_t hi;
        logic  preset;
        data_t value;
    } row_t;

    localparam int    NUM_ROWS    = 24;
    localparam addr_t RESULT_ADDR = 16'h00F0;

    logic  clk   = 1'b0;
    logic  reset = 1'b1;
    logic  rdy;
    logic  rw;
    logic  sync;
    data_t data_in;
    data_t data_out;
    addr_t address;
    logic  write_seen;
    logic  fetch_seen;
    addr_t write_addr;
    addr_t fetch_addr;
    data_t write_byte;

    row_t  rows [NUM_ROWS];
    data_t image [0:65535];  // memory as the reference model sees it
    addr_t exp_fetch [$];
    addr_t exp_waddr [$];
    data_t exp_wdata [$];
    data_t a_ref       = '0;
    logic  c_ref       = 1'b0;
    logic  done        = 1'b0;
    int    cycle_count = 0;
    int    cycle_limit = 0;

    always #5 clk = ~clk;

    cpu_core i_cpu_core (
        .clk      (clk),
        .reset    (reset),
        .rdy      (rdy),
        .data_in  (data_in),
        .address  (address),
        .data_out (data_out),
        .rw       (rw),
        .sync     (sync)
    );

    tb_memory i_tb_memory (
        .clk        (clk),
        .reset      (reset),
        .address    (address),
        .write_data (data_out),
        .rw         (rw),
        .sync       (sync),
        .read_data  (data_in),
        .rdy        (rdy),
        .write_seen (write_seen),
        .write_addr (write_addr),
        .write_byte (write_byte),
        .fetch_seen (fetch_seen),
        .fetch_addr (fetch_addr)
    );

    task automatic stop_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_data(input data_t got, input data_t expected, input string what);
        if (got !== expected) begin
            $display("[ERROR] %0d ns: %s is %02h, expected %02h", $time, what, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t expected, input string what);
        if (got !== expected) begin
            $display("[ERROR] %0d ns: %s is %04h, expected %04h", $time, what, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic put_byte(input addr_t a, input data_t d);
        image[a]           = d;
        i_tb_memory.mem[a] = d;
    endtask

    task automatic expect_write(input addr_t a, input data_t d);
        exp_waddr.push_back(a);
        exp_wdata.push_back(d);
    endtask

    function automatic int op_len(input data_t op);
        case (op)
            `OP_LDA_ABS, `OP_STA_ABS, `OP_JMP_ABS: return 3;
            `OP_LDA_IMM, `OP_LDA_ZPG, `OP_STA_ZPG, `OP_ADC_IMM, `OP_ADC_ZPG, `OP_AND_IMM,
            `OP_AND_ZPG, `OP_ORA_IMM, `OP_ORA_ZPG, `OP_EOR_IMM, `OP_EOR_ZPG, `OP_ASL_ZPG:
                return 2;
            default: return 1;  // implied and unknown opcodes
        endcase
    endfunction

    function automatic logic changes_a(input data_t op);
        case (op)
            `OP_LDA_IMM, `OP_LDA_ZPG, `OP_LDA_ABS, `OP_ADC_IMM, `OP_ADC_ZPG, `OP_AND_IMM,
            `OP_AND_ZPG, `OP_ORA_IMM, `OP_ORA_ZPG, `OP_EOR_IMM, `OP_EOR_ZPG, `OP_ASL_A:
                return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // expected effect of one instruction on A, C and memory
    task automatic predict(input data_t op, input addr_t ea, input data_t lo);
        data_t      src;
        logic [8:0] sum;
        src = image[ea];
        case (op)
            `OP_LDA_IMM, `OP_ADC_IMM, `OP_AND_IMM, `OP_ORA_IMM, `OP_EOR_IMM: src = lo;
            default: ;
        endcase
        case (op)
            `OP_LDA_IMM, `OP_LDA_ZPG, `OP_LDA_ABS: a_ref = src;
            `OP_ADC_IMM, `OP_ADC_ZPG: begin
                sum   = {1'b0, a_ref} + {1'b0, src} + {8'h00, c_ref};
                a_ref = sum[7:0];
                c_ref = sum[8];  // carry out of bit 7
            end
            `OP_AND_IMM, `OP_AND_ZPG: a_ref = a_ref & src;
            `OP_ORA_IMM, `OP_ORA_ZPG: a_ref = a_ref | src;
            `OP_EOR_IMM, `OP_EOR_ZPG: a_ref = a_ref ^ src;
            `OP_ASL_A: begin
                c_ref = a_ref[7];
                a_ref = {a_ref[6:0], 1'b0};
            end
            `OP_ASL_ZPG: begin
                c_ref     = src[7];
                image[ea] = {src[6:0], 1'b0};
                expect_write(ea, image[ea]);
            end
            `OP_STA_ZPG, `OP_STA_ABS: begin
                image[ea] = a_ref;
                expect_write(ea, a_ref);
            end
            `OP_CLC: c_ref = 1'b0;
            `OP_SEC: c_ref = 1'b1;
            default: ;
        endcase
    endtask

    task automatic fill_table();
        rows[0]  = '{`OP_LDA_IMM, 8'h5A, 8'h00, 1'b0, 8'h00};
        rows[1]  = '{`OP_LDA_ZPG, 8'h10, 8'h00, 1'b1, 8'h81};
        rows[2]  = '{`OP_LDA_ABS, 8'h34, 8'h12, 1'b1, 8'hFF};
        rows[3]  = '{`OP_SEC,     8'h00, 8'h00, 1'b0, 8'h00};
        rows[4]  = '{`OP_ADC_IMM, 8'hFF, 8'h00, 1'b0, 8'h00};
        rows[5]  = '{`OP_ADC_IMM, 8'h00, 8'h00, 1'b0, 8'h00};  // shows the carry of row 4
        rows[6]  = '{`OP_CLC,     8'h00, 8'h00, 1'b0, 8'h00};
        rows[7]  = '{`OP_ADC_ZPG, 8'h11, 8'h00, 1'b1, 8'h20};
        rows[8]  = '{`OP_AND_IMM, 8'hF0, 8'h00, 1'b0, 8'h00};
        rows[9]  = '{`OP_ORA_IMM, 8'h3C, 8'h00, 1'b0, 8'h00};
        rows[10] = '{`OP_EOR_IMM, 8'hFF, 8'h00, 1'b0, 8'h00};
        rows[11] = '{`OP_ASL_A,   8'h00, 8'h00, 1'b0, 8'h00};
        rows[12] = '{`OP_ADC_IMM, 8'h00, 8'h00, 1'b0, 8'h00};
        rows[13] = '{`OP_ASL_ZPG, 8'h12, 8'h00, 1'b1, 8'hC5};
        rows[14] = '{`OP_ADC_IMM, 8'h00, 8'h00, 1'b0, 8'h00};
        rows[15] = '{`OP_STA_ABS, 8'h56, 8'h34, 1'b0, 8'h00};
        rows[16] = '{`OP_JMP_ABS, 8'h04, 8'h00, 1'b0, 8'h00};
        rows[17] = '{8'hEA,       8'h00, 8'h00, 1'b0, 8'h00};  // not in the subset
        rows[18] = '{`OP_LDA_ZPG, 8'h12, 8'h00, 1'b0, 8'h00};  // reads back the ASL result
        rows[19] = '{`OP_ADC_ZPG, 8'h13, 8'h00, 1'b1, 8'hFF};
        rows[20] = '{`OP_ADC_IMM, 8'h00, 8'h00, 1'b0, 8'h00};
        rows[21] = '{`OP_AND_ZPG, 8'h14, 8'h00, 1'b1, 8'hF5};
        rows[22] = '{`OP_ORA_ZPG, 8'h15, 8'h00, 1'b1, 8'h81};
        rows[23] = '{`OP_EOR_ZPG, 8'h16, 8'h00, 1'b1, 8'h0F};
    endtask

    // lays the rows out from the reset address and predicts every fetch and write
    task automatic assemble();
        addr_t pc;
        addr_t ea;
        addr_t target;
        row_t  r;
        pc = `CPU_RESET_PC;
        for (int i = 0; i < NUM_ROWS; i++) begin
            r  = rows[i];
            ea = (op_len(r.opcode) == 3) ? {r.hi, r.lo} : {8'h00, r.lo};
            exp_fetch.push_back(pc);
            if (r.preset) begin
                put_byte(ea, r.value);
            end
            if (r.opcode == `OP_JMP_ABS) begin
                target = pc + 16'd3 + addr_t'(r.lo);
                put_byte(pc, r.opcode);
                put_byte(pc + 16'd1, target[7:0]);
                put_byte(pc + 16'd2, target[15:8]);
                for (int k = 0; k < int'(r.lo); k++) begin
                    put_byte(pc + 16'd3 + addr_t'(k), `OP_LDA_IMM);  // executing these shows up
                end
                pc = target;
            end else begin
                put_byte(pc, r.opcode);
                if (op_len(r.opcode) >= 2) begin
                    put_byte(pc + 16'd1, r.lo);
                end
                if (op_len(r.opcode) == 3) begin
                    put_byte(pc + 16'd2, r.hi);
                end
                pc = pc + addr_t'(op_len(r.opcode));
                predict(r.opcode, ea, r.lo);
                if (changes_a(r.opcode)) begin
                    exp_fetch.push_back(pc);
                    put_byte(pc, `OP_STA_ZPG);
                    put_byte(pc + 16'd1, RESULT_ADDR[7:0]);
                    pc = pc + 16'd2;
                    predict(`OP_STA_ZPG, RESULT_ADDR, RESULT_ADDR[7:0]);
                end
            end
        end
        // the closing jump targets itself, so its address is fetched twice in a row
        put_byte(pc, `OP_JMP_ABS);
        put_byte(pc + 16'd1, pc[7:0]);
        put_byte(pc + 16'd2, pc[15:8]);
        exp_fetch.push_back(pc);
        exp_fetch.push_back(pc);
        cycle_limit = int'(pc + 16'd3 - `CPU_RESET_PC) * 6 * 2 + 100;
    endtask

    initial begin
        for (int i = 0; i < 65536; i++) begin
            put_byte(addr_t'(i), i[7:0] ^ i[15:8] ^ 8'h3C);
        end
        fill_table();
        assemble();
        repeat (10) begin
            @(posedge clk);
        end
        @(negedge clk);
        reset = 1'b0;
        check_addr(address, `CPU_RESET_PC, "first bus address");
        if (rw !== 1'b1 || sync !== 1'b1) begin
            $display("first cycle after reset is not an opcode read (rw=%b sync=%b)", rw, sync);
            stop_with_failure();
        end
        wait (done);
        @(negedge clk);
        if (exp_waddr.size() != 0) begin
            $display("%0d expected writes never appeared on the bus", exp_waddr.size());
            stop_with_failure();
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

    // completed cycles are registered in the memory model, so they are stable here
    always @(negedge clk) begin
        if (!reset && !done) begin
            if (write_seen) begin
                if (exp_waddr.size() == 0) begin
                    $display("unexpected write of %02h to %04h", write_byte, write_addr);
                    stop_with_failure();
                end else begin
                    check_addr(write_addr, exp_waddr.pop_front(), "write address");
                    check_data(write_byte, exp_wdata.pop_front(), "write data");
                end
            end
            if (fetch_seen) begin
                check_addr(fetch_addr, exp_fetch.pop_front(), "fetch address");
                done = (exp_fetch.size() == 0);
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                $display("timeout: final jump not reached within %0d cycles", cycle_limit);
                stop_with_failure();
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_memory (
    input  wire                 clk,
    input  wire                 reset,
    input  wire cpu_pkg::addr_t address,
    input  wire cpu_pkg::data_t write_data,
    input  wire                 rw,
    input  wire                 sync,
    output cpu_pkg::data_t      read_data,
    output logic                rdy,
    output logic                write_seen,
    output cpu_pkg::addr_t      write_addr,
    output cpu_pkg::data_t      write_byte,
    output logic                fetch_seen,
    output cpu_pkg::addr_t      fetch_addr
);
    import cpu_pkg::*;

    data_t       mem [0:65535];  // filled by the testbench before reset
    logic [31:0] rnd_state = 32'h218ff9a1;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign read_data = mem[address];

    initial begin
        rdy = 1'b1;
    end

    always @(negedge clk) begin
        rnd_state = xorshift32(rnd_state);
        rdy       = (rnd_state[1:0] != 2'b00);  // low on about one cycle in four
    end

    // a cycle only completes when rdy is high, stalled cycles are not reported
    always @(posedge clk) begin
        write_seen <= 1'b0;
        fetch_seen <= 1'b0;
        if (!reset && rdy) begin
            if (!rw) begin
                mem[address] = write_data;  // no read is sampled in a write cycle
                write_seen <= 1'b1;
                write_addr <= address;
                write_byte <= write_data;
            end
            if (sync) begin
                fetch_seen <= 1'b1;
                fetch_addr <= address;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_core (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 rdy,
    input  wire cpu_pkg::data_t data_in,
    output cpu_pkg::addr_t      address,
    output cpu_pkg::data_t      data_out,
    output logic                rw,
    output logic                sync
);
    import cpu_pkg::*;

    ctrl_t ctrl;  // control word for the current bus cycle

    instruction_decode i_instruction_decode (
        .clk     (clk),
        .reset   (reset),
        .rdy     (rdy),
        .data_in (data_in),
        .ctrl    (ctrl),
        .sync    (sync)
    );

    // both blocks see the same rdy so a stall repeats the whole cycle
    datapath i_datapath (
        .clk      (clk),
        .reset    (reset),
        .rdy      (rdy),
        .ctrl     (ctrl),
        .data_in  (data_in),
        .address  (address),
        .data_out (data_out),
        .rw       (rw)
    );

endmodule

`default_nettype wire

// ==== hdl/datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module datapath (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 rdy,
    input  wire cpu_pkg::ctrl_t ctrl,
    input  wire cpu_pkg::data_t data_in,
    output cpu_pkg::addr_t      address,
    output cpu_pkg::data_t      data_out,
    output logic                rw
);
    import cpu_pkg::*;

    addr_t   pc;
    data_t   a_reg;
    data_t   adl;
    data_t   adh;
    data_t   data_latch;
    status_t status;

    data_t   alu_b;
    data_t   alu_result;
    status_t alu_flags;
    data_t   next_adh;

    assign alu_b = ctrl.alu_b_from_bus ? data_in : data_latch;

    alu i_alu (
        .op       (ctrl.alu_op),
        .a        (a_reg),
        .b        (alu_b),
        .carry_in (status.c),
        .result   (alu_result),
        .flags    (alu_flags)
    );

    // JMP loads PC in the same cycle the high byte arrives
    assign next_adh = ctrl.latch_adh ? data_in : adh;

    always_ff @(posedge clk) begin
        if (reset) begin
            a_reg  <= '0;
            pc     <= `CPU_RESET_PC;
            status <= '0;
        end else if (rdy) begin
            if (ctrl.load_a) begin
                a_reg <= alu_result;
            end
            if (ctrl.jump) begin
                pc <= {next_adh, adl};
            end else if (ctrl.pc_inc) begin
                pc <= pc + addr_t'(1);
            end
            if (ctrl.update_flags) begin
                status <= alu_flags;
            end else if (ctrl.set_c) begin
                status.c <= 1'b1;
            end else if (ctrl.clr_c) begin
                status.c <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (ctrl.latch_adl) begin
                adl <= data_in;
            end
            adh <= next_adh;
            // when no memory byte is taken the latch follows A, which gives ASL A its operand
            data_latch <= ctrl.latch_data ? data_in : a_reg;
        end
    end

    always_comb begin
        case (ctrl.addr_src)
            ADDR_ZPG: address = {8'h00, adl};
            ADDR_ABS: address = {adh, adl};
            default:  address = pc;
        endcase
    end

    assign data_out = ctrl.write_alu ? alu_result : a_reg;
    assign rw       = ~(ctrl.write_alu | ctrl.write_a);  // low only in write cycles

endmodule

`default_nettype wire

// ==== hdl/instruction_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_config.svh"

module instruction_decode (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 rdy,
    input  wire cpu_pkg::data_t data_in,
    output cpu_pkg::ctrl_t      ctrl,
    output logic                sync
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        FETCH,
        OPERAND,
        ADDR_HIGH,
        READ,
        MODIFY,
        WRITE
    } state_t;

    // addressing mode of the opcode, implied covers unknown opcodes too
    typedef enum logic [1:0] {
        M_NONE,
        M_IMM,
        M_ZPG,
        M_ABS
    } mode_t;

    state_t  state;
    state_t  next_state;
    data_t   opcode;
    mode_t   mode;
    alu_op_t alu_sel;
    logic    is_store;
    logic    is_rmw;
    logic    is_jump;

    function automatic mode_t op_mode(input data_t op);
        case (op)
            `OP_LDA_IMM, `OP_ADC_IMM, `OP_AND_IMM, `OP_ORA_IMM, `OP_EOR_IMM:
                op_mode = M_IMM;
            `OP_LDA_ZPG, `OP_STA_ZPG, `OP_ADC_ZPG, `OP_AND_ZPG, `OP_ORA_ZPG,
            `OP_EOR_ZPG, `OP_ASL_ZPG:
                op_mode = M_ZPG;
            `OP_LDA_ABS, `OP_STA_ABS, `OP_JMP_ABS:
                op_mode = M_ABS;
            default:
                op_mode = M_NONE;
        endcase
    endfunction

    function automatic alu_op_t op_alu(input data_t op);
        case (op)
            `OP_ADC_IMM, `OP_ADC_ZPG: op_alu = ALU_ADC;
            `OP_AND_IMM, `OP_AND_ZPG: op_alu = ALU_AND;
            `OP_ORA_IMM, `OP_ORA_ZPG: op_alu = ALU_ORA;
            `OP_EOR_IMM, `OP_EOR_ZPG: op_alu = ALU_EOR;
            `OP_ASL_A, `OP_ASL_ZPG:   op_alu = ALU_ASL;
            default:                  op_alu = ALU_PASS;  // LDA and everything else
        endcase
    endfunction

    assign alu_sel  = op_alu(opcode);
    assign is_store = (opcode == `OP_STA_ZPG) || (opcode == `OP_STA_ABS);
    assign is_rmw   = (opcode == `OP_ASL_ZPG);
    assign is_jump  = (opcode == `OP_JMP_ABS);
    assign sync     = (state == FETCH);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else if (rdy) begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && state == FETCH) begin
            opcode <= data_in;
            mode   <= op_mode(data_in);
        end
    end

    always_comb begin
        ctrl          = '0;
        ctrl.addr_src = ADDR_PC;
        ctrl.alu_op   = ALU_PASS;
        next_state    = state;
        case (state)
            FETCH: begin
                ctrl.pc_inc = 1'b1;
                next_state  = OPERAND;  // every instruction has a second cycle
            end
            OPERAND: begin
                case (mode)
                    M_IMM: begin
                        ctrl.pc_inc         = 1'b1;
                        ctrl.alu_op         = alu_sel;
                        ctrl.alu_b_from_bus = 1'b1;
                        ctrl.load_a         = 1'b1;
                        ctrl.update_flags   = 1'b1;
                        next_state          = FETCH;
                    end
                    M_ZPG: begin
                        ctrl.pc_inc    = 1'b1;
                        ctrl.latch_adl = 1'b1;
                        next_state     = is_store ? WRITE : READ;
                    end
                    M_ABS: begin
                        ctrl.pc_inc    = 1'b1;
                        ctrl.latch_adl = 1'b1;
                        next_state     = ADDR_HIGH;
                    end
                    default: begin
                        // dummy read of the next byte, PC stays put
                        if (opcode == `OP_ASL_A) begin
                            ctrl.alu_op       = ALU_ASL;  // data latch holds A here
                            ctrl.load_a       = 1'b1;
                            ctrl.update_flags = 1'b1;
                        end
                        ctrl.clr_c = (opcode == `OP_CLC);
                        ctrl.set_c = (opcode == `OP_SEC);
                        next_state = FETCH;
                    end
                endcase
            end
            ADDR_HIGH: begin
                ctrl.pc_inc    = 1'b1;
                ctrl.latch_adh = 1'b1;
                if (is_jump) begin
                    ctrl.jump  = 1'b1;
                    next_state = FETCH;
                end else begin
                    next_state = is_store ? WRITE : READ;
                end
            end
            READ: begin
                ctrl.addr_src = (mode == M_ABS) ? ADDR_ABS : ADDR_ZPG;
                if (is_rmw) begin
                    ctrl.latch_data = 1'b1;
                    next_state      = MODIFY;
                end else begin
                    ctrl.alu_op         = alu_sel;
                    ctrl.alu_b_from_bus = 1'b1;
                    ctrl.load_a         = 1'b1;
                    ctrl.update_flags   = 1'b1;
                    next_state          = FETCH;
                end
            end
            MODIFY: begin
                // same byte read again so the data latch keeps it
                ctrl.addr_src   = ADDR_ZPG;
                ctrl.latch_data = 1'b1;
                next_state      = WRITE;
            end
            WRITE: begin
                ctrl.addr_src = (mode == M_ABS) ? ADDR_ABS : ADDR_ZPG;
                if (is_rmw) begin
                    ctrl.alu_op       = ALU_ASL;
                    ctrl.write_alu    = 1'b1;
                    ctrl.update_flags = 1'b1;
                end else begin
                    ctrl.write_a = 1'b1;
                end
                next_state = FETCH;
            end
            default: begin
                next_state = FETCH;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_op_t op,
    input  wire cpu_pkg::data_t   a,
    input  wire cpu_pkg::data_t   b,
    input  wire                   carry_in,
    output cpu_pkg::data_t        result,
    output cpu_pkg::status_t      flags
);
    import cpu_pkg::*;

    logic [8:0] sum;
    logic       carry_out;

    assign sum = {1'b0, a} + {1'b0, b} + {8'd0, carry_in};  // ninth bit is the carry

    always_comb begin
        carry_out = carry_in;  // pass and logic ops leave C alone
        case (op)
            ALU_PASS: begin
                result = b;
            end
            ALU_ADC: begin
                result    = sum[7:0];
                carry_out = sum[8];
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_ORA: begin
                result = a | b;
            end
            ALU_EOR: begin
                result = a ^ b;
            end
            ALU_ASL: begin
                result    = {b[6:0], 1'b0};
                carry_out = b[7];
            end
            default: begin
                result = b;
            end
        endcase
    end

    always_comb begin
        flags.n = result[7];
        flags.z = (result == '0);
        flags.c = carry_out;
    end

endmodule

`default_nettype wire

// ==== hdl/cpu_pkg.sv ====
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`CPU_DATA_WIDTH-1:0] data_t;

    typedef enum logic [2:0] {
        ALU_PASS,  // result is operand b, used by LDA
        ALU_ADC,
        ALU_AND,
        ALU_ORA,
        ALU_EOR,
        ALU_ASL    // shifts operand b, carry from bit 7
    } alu_op_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
    } status_t;

    // where the bus address comes from in a given cycle
    typedef enum logic [1:0] {
        ADDR_PC,
        ADDR_ZPG,  // {8'h00, adl}
        ADDR_ABS   // {adh, adl}
    } addr_src_t;

    // one control word per bus cycle, decoder to datapath
    typedef struct packed {
        addr_src_t addr_src;
        logic      pc_inc;
        logic      latch_adl;
        logic      latch_adh;
        logic      latch_data;      // data latch takes data_in, otherwise it follows A
        alu_op_t   alu_op;
        logic      alu_b_from_bus;  // b from data_in, otherwise from the data latch
        logic      load_a;
        logic      write_alu;       // alu result on data_out, write cycle
        logic      write_a;         // A on data_out, write cycle
        logic      update_flags;
        logic      set_c;
        logic      clr_c;
        logic      jump;            // PC loaded from the address latches
    } ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define CPU_ADDR_WIDTH 16
`define CPU_DATA_WIDTH 8

// first opcode fetch after reset, no vector read
`define CPU_RESET_PC 16'h0200

`define OP_LDA_IMM 8'hA9
`define OP_LDA_ZPG 8'hA5
`define OP_LDA_ABS 8'hAD
`define OP_STA_ZPG 8'h85
`define OP_STA_ABS 8'h8D
`define OP_ADC_IMM 8'h69
`define OP_ADC_ZPG 8'h65
`define OP_AND_IMM 8'h29
`define OP_AND_ZPG 8'h25
`define OP_ORA_IMM 8'h09
`define OP_ORA_ZPG 8'h05
`define OP_EOR_IMM 8'h49
`define OP_EOR_ZPG 8'h45
`define OP_ASL_A   8'h0A
`define OP_ASL_ZPG 8'h06
`define OP_JMP_ABS 8'h4C
`define OP_CLC     8'h18
`define OP_SEC     8'h38

`endif
